//--- common/exu_defs.svh
// data width, divider counter width and ALU control codes, included by the execute unit sources
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath
`define XLEN 64
`define ALU_CTR_W 5

// enough for the 64 steps of a doubleword divide
`define DIV_CNT_W 7

// arithmetic and compare
`define ALU_ADD    5'b00000
`define ALU_SUB    5'b00001
`define ALU_SLT    5'b00010
`define ALU_SLTU   5'b00011

// logic and shifts
`define ALU_XOR    5'b00100
`define ALU_AND    5'b00101
`define ALU_OR     5'b00110
`define ALU_SLL    5'b00111
`define ALU_SRL    5'b01000
`define ALU_SRA    5'b01001

// M extension, divide codes go to the divider
`define ALU_MUL    5'b01010
`define ALU_DIV    5'b01011
`define ALU_DIVU   5'b01100
`define ALU_REM    5'b01101
`define ALU_REMU   5'b01110
`define ALU_MULH   5'b11001
`define ALU_MULHSU 5'b11010
`define ALU_MULHU  5'b11011

`define ALU_COPY   5'b01111

`endif

//--- common/exu_pkg.sv
// types shared by the execute unit modules, imported inside each module that needs them
`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

  // one register-wide data word
  typedef logic [`XLEN-1:0] xlen_t;

  // ALU operation code, values from exu_defs.svh
  typedef logic [`ALU_CTR_W-1:0] alu_ctr_t;

  // shift amount for the doubleword forms
  typedef logic [$clog2(`XLEN)-1:0] shamt_t;

  // divider sequencing
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_e;

endpackage

`default_nettype wire

//--- rtl/mux_key.sv
// key-to-data lookup mux with a default, instantiated by the ALU for result and flag select
`default_nettype none

module mux_key #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  wire logic [KEY_LEN-1:0]                   i_key,
  input  wire logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] i_lut,
  input  wire logic [DATA_LEN-1:0]                  i_default,
  output logic      [DATA_LEN-1:0]                  o_out
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  logic [KEY_LEN-1:0]  key_list  [NR_KEY];
  logic [DATA_LEN-1:0] data_list [NR_KEY];

  // each pair is {key, data}, first pair in the concatenation sits at the top
  for (genvar i = 0; i < NR_KEY; i++) begin : g_pair
    assign key_list[i]  = i_lut[PAIR_LEN*i+DATA_LEN +: KEY_LEN];
    assign data_list[i] = i_lut[PAIR_LEN*i +: DATA_LEN];
  end

  always_comb begin
    o_out = i_default;
    for (int i = 0; i < NR_KEY; i++) begin
      if (key_list[i] == i_key) begin
        o_out = data_list[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- alu/alu.sv
// combinational ALU for RV64I and the M multiplies that exu drives with the operands of a new op
`default_nettype none

`include "exu_defs.svh"

module alu (
  input  wire exu_pkg::xlen_t    i_src_a,
  input  wire exu_pkg::xlen_t    i_src_b,
  input  wire exu_pkg::xlen_t    i_imm,
  input  wire exu_pkg::alu_ctr_t i_alu_ctr,
  input  wire logic              i_word_cut,
  output exu_pkg::xlen_t         o_result,
  output logic                   o_zero,
  output logic                   o_less
);

  import exu_pkg::*;

  shamt_t             shamt;
  xlen_t              add_res;
  xlen_t              sub_res;
  logic               sub_carry;
  logic               signed_less;
  logic               unsigned_less;
  xlen_t              srl_src;
  xlen_t              sra_src;
  xlen_t              sll_res;
  xlen_t              srl_res;
  xlen_t              sra_res;
  logic [2*`XLEN-1:0] prod_uu;
  xlen_t              corr_a;
  xlen_t              corr_b;
  xlen_t              mul_res;
  xlen_t              mulh_res;
  xlen_t              mulhsu_res;
  xlen_t              mulhu_res;
  xlen_t              sel_res;

  // W forms only look at 5 shift bits
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  assign add_res = i_src_a + i_src_b;

  // carry out of a + ~b + 1 means a >= b unsigned
  assign {sub_carry, sub_res} = {1'b0, i_src_a} + {1'b0, ~i_src_b} + 1'b1;

  assign o_zero = (sub_res == '0);

  // differing signs decide directly and equal signs use the difference sign
  assign signed_less = (i_src_a[`XLEN-1] != i_src_b[`XLEN-1]) ? i_src_a[`XLEN-1]
                                                               : sub_res[`XLEN-1];
  assign unsigned_less = ~sub_carry;

  // srlw shifts the zero-extended low word and sraw the sign-extended one
  assign srl_src = i_word_cut ? {32'b0, i_src_a[31:0]} : i_src_a;
  assign sra_src = i_word_cut ? {{32{i_src_a[31]}}, i_src_a[31:0]} : i_src_a;

  assign sll_res = i_src_a << shamt;
  assign srl_res = srl_src >> shamt;
  assign sra_res = xlen_t'($signed(sra_src) >>> shamt);

  // signed high halves correct the upper word of one unsigned product
  assign prod_uu = {{`XLEN{1'b0}}, i_src_a} * {{`XLEN{1'b0}}, i_src_b};
  assign corr_a  = i_src_a[`XLEN-1] ? i_src_b : '0;
  assign corr_b  = i_src_b[`XLEN-1] ? i_src_a : '0;

  assign mul_res    = prod_uu[`XLEN-1:0];
  assign mulhu_res  = prod_uu[2*`XLEN-1:`XLEN];
  assign mulhsu_res = mulhu_res - corr_a;
  assign mulh_res   = mulhu_res - corr_a - corr_b;

  mux_key #(
    .NR_KEY   (2),
    .KEY_LEN  (`ALU_CTR_W),
    .DATA_LEN (1)
  ) u_less_mux (
    .i_key     (i_alu_ctr),
    .i_lut     ({`ALU_SLT,  signed_less,
                 `ALU_SLTU, unsigned_less}),
    .i_default (1'b0),
    .o_out     (o_less)
  );

  // divide codes fall to the default and exu takes those from the divider
  mux_key #(
    .NR_KEY   (15),
    .KEY_LEN  (`ALU_CTR_W),
    .DATA_LEN (`XLEN)
  ) u_result_mux (
    .i_key     (i_alu_ctr),
    .i_lut     ({`ALU_COPY,   i_imm,
                 `ALU_ADD,    add_res,
                 `ALU_SUB,    sub_res,
                 `ALU_SLT,    xlen_t'(signed_less),
                 `ALU_SLTU,   xlen_t'(unsigned_less),
                 `ALU_XOR,    i_src_a ^ i_src_b,
                 `ALU_AND,    i_src_a & i_src_b,
                 `ALU_OR,     i_src_a | i_src_b,
                 `ALU_SLL,    sll_res,
                 `ALU_SRL,    srl_res,
                 `ALU_SRA,    sra_res,
                 `ALU_MUL,    mul_res,
                 `ALU_MULH,   mulh_res,
                 `ALU_MULHSU, mulhsu_res,
                 `ALU_MULHU,  mulhu_res}),
    .i_default ('0),
    .o_out     (sel_res)
  );

  assign o_result = i_word_cut ? {{32{sel_res[31]}}, sel_res[31:0]} : sel_res;

endmodule

`default_nettype wire

//--- alu/alu_divider.sv
// iterative restoring divider for div/divu/rem/remu and the W forms that exu starts with a pulse
`default_nettype none

`include "exu_defs.svh"

module alu_divider (
  input  wire logic           i_clk,
  input  wire logic           i_rst_n,
  input  wire logic           i_start,
  input  wire exu_pkg::xlen_t i_dividend,
  input  wire exu_pkg::xlen_t i_divisor,
  input  wire logic           i_is_signed,
  input  wire logic           i_is_rem,
  input  wire logic           i_word_cut,
  output logic                o_done,
  output exu_pkg::xlen_t      o_result
);

  import exu_pkg::*;

  localparam logic [`DIV_CNT_W-1:0] STEPS_W = 32;
  localparam logic [`DIV_CNT_W-1:0] STEPS_D = `XLEN;

  div_state_e            state_q;
  logic [`DIV_CNT_W-1:0] cnt_q;
  xlen_t                 rem_q;
  xlen_t                 quo_q;
  xlen_t                 divisor_q;
  xlen_t                 dividend_q;
  logic                  neg_quo_q;
  logic                  neg_rem_q;
  logic                  is_rem_q;
  logic                  word_q;
  logic                  by_zero_q;
  xlen_t                 dividend_ext;
  xlen_t                 divisor_ext;
  logic                  dividend_neg;
  logic                  divisor_neg;
  xlen_t                 dividend_mag;
  xlen_t                 divisor_mag;
  logic [`XLEN:0]        rem_shift;
  logic [`XLEN+1:0]      trial;
  logic                  trial_fits;
  xlen_t                 quo_fix;
  xlen_t                 rem_fix;
  xlen_t                 raw_result;

  // widen W operands by signedness before taking magnitudes
  assign dividend_ext = !i_word_cut ? i_dividend :
                        i_is_signed ? {{32{i_dividend[31]}}, i_dividend[31:0]} :
                                      {32'b0, i_dividend[31:0]};
  assign divisor_ext  = !i_word_cut ? i_divisor :
                        i_is_signed ? {{32{i_divisor[31]}}, i_divisor[31:0]} :
                                      {32'b0, i_divisor[31:0]};

  assign dividend_neg = i_is_signed & dividend_ext[`XLEN-1];
  assign divisor_neg  = i_is_signed & divisor_ext[`XLEN-1];
  assign dividend_mag = dividend_neg ? -dividend_ext : dividend_ext;
  assign divisor_mag  = divisor_neg ? -divisor_ext : divisor_ext;

  // restoring step subtracts only if the divisor fits
  assign rem_shift  = {rem_q, quo_q[`XLEN-1]};
  assign trial      = {1'b0, rem_shift} - {2'b0, divisor_q};
  assign trial_fits = ~trial[`XLEN+1];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (i_start) begin
            state_q <= DIV_BUSY;
            cnt_q   <= i_word_cut ? STEPS_W : STEPS_D;
          end
        end
        DIV_BUSY: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == 1) begin
            state_q <= DIV_DONE;
          end
        end
        default: begin
          state_q <= DIV_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == DIV_IDLE && i_start) begin
      rem_q      <= '0;
      // W form starts with the low word at the top so 32 steps cover it
      quo_q      <= i_word_cut ? {dividend_mag[31:0], 32'b0} : dividend_mag;
      divisor_q  <= divisor_mag;
      dividend_q <= dividend_ext;
      neg_quo_q  <= dividend_neg ^ divisor_neg;
      neg_rem_q  <= dividend_neg;
      is_rem_q   <= i_is_rem;
      word_q     <= i_word_cut;
      by_zero_q  <= (divisor_ext == '0);
    end else if (state_q == DIV_BUSY) begin
      rem_q <= trial_fits ? trial[`XLEN-1:0] : rem_shift[`XLEN-1:0];
      quo_q <= {quo_q[`XLEN-2:0], trial_fits};
    end
  end

  // overflow quotient keeps the bits of the most negative dividend
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  always_comb begin
    if (by_zero_q) begin
      raw_result = is_rem_q ? dividend_q : '1;
    end else begin
      raw_result = is_rem_q ? rem_fix : quo_fix;
    end
  end

  assign o_result = word_q ? {{32{raw_result[31]}}, raw_result[31:0]} : raw_result;
  assign o_done   = (state_q == DIV_DONE);

  // exu must hold off a new divide until the last one has finished
  a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_start |-> state_q == DIV_IDLE);

endmodule

`default_nettype wire

//--- rtl/exu.sv
// execute unit top, takes one op over valid/ready and returns a registered result and flags
`default_nettype none

`include "exu_defs.svh"

module exu (
  input  wire logic              i_clk,
  input  wire logic              i_rst_n,
  input  wire logic              i_valid,
  output logic                   o_ready,
  input  wire exu_pkg::alu_ctr_t i_alu_ctr,
  input  wire exu_pkg::xlen_t    i_src_a,
  input  wire exu_pkg::xlen_t    i_src_b,
  input  wire exu_pkg::xlen_t    i_imm,
  input  wire logic              i_word_cut,
  input  wire logic              i_out_ready,
  output logic                   o_valid,
  output exu_pkg::xlen_t         o_result,
  output logic                   o_zero,
  output logic                   o_less
);

  import exu_pkg::*;

  logic  accept;
  logic  is_div;
  logic  div_signed;
  logic  div_rem;
  logic  div_start;
  logic  div_done;
  logic  div_pend_q;
  logic  alu_zero;
  logic  alu_less;
  xlen_t alu_result;
  xlen_t div_result;

  // one op in flight, ready again once its result is gone
  assign o_ready = ~div_pend_q & ~o_valid;
  assign accept  = i_valid & o_ready;

  always_comb begin
    is_div     = 1'b0;
    div_signed = 1'b0;
    div_rem    = 1'b0;
    case (i_alu_ctr)
      `ALU_DIV: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
      end
      `ALU_DIVU: begin
        is_div = 1'b1;
      end
      `ALU_REM: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
        div_rem    = 1'b1;
      end
      `ALU_REMU: begin
        is_div  = 1'b1;
        div_rem = 1'b1;
      end
      default: begin
        is_div = 1'b0;
      end
    endcase
  end

  assign div_start = accept & is_div;

  alu u_alu (
    .i_src_a    (i_src_a),
    .i_src_b    (i_src_b),
    .i_imm      (i_imm),
    .i_alu_ctr  (i_alu_ctr),
    .i_word_cut (i_word_cut),
    .o_result   (alu_result),
    .o_zero     (alu_zero),
    .o_less     (alu_less)
  );

  alu_divider u_divider (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (div_start),
    .i_dividend  (i_src_a),
    .i_divisor   (i_src_b),
    .i_is_signed (div_signed),
    .i_is_rem    (div_rem),
    .i_word_cut  (i_word_cut),
    .o_done      (div_done),
    .o_result    (div_result)
  );

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid    <= 1'b0;
      div_pend_q <= 1'b0;
    end else begin
      if (o_valid && i_out_ready) begin
        o_valid <= 1'b0;
      end
      if (accept && !is_div) begin
        o_valid <= 1'b1;
      end
      if (div_start) begin
        div_pend_q <= 1'b1;
      end
      if (div_done) begin
        div_pend_q <= 1'b0;
        o_valid    <= 1'b1;
      end
    end
  end

  // flags come from the ALU at acceptance, also for divides
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_zero <= alu_zero;
      o_less <= alu_less;
      if (!is_div) begin
        o_result <= alu_result;
      end
    end else if (div_done) begin
      o_result <= div_result;
    end
  end

  a_hold_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid && !i_out_ready |=> o_valid && $stable(o_result));

endmodule

`default_nettype wire

//--- dv/exu_tb.sv
// directed testbench for the execute unit that runs as the top of the sim.f build
`default_nettype none

`include "exu_defs.svh"

module exu_tb;

  import exu_pkg::*;

  localparam int unsigned SEED = 32'h14df_701f;
  localparam int NUM_OPS       = 230;
  localparam int MARGIN_CYCLES = 400;
  localparam int DONE_LIMIT    = 100;
  localparam int READY_LIMIT   = 100;

  logic     clk;
  logic     rst_n;
  logic     i_valid;
  logic     o_ready;
  alu_ctr_t i_alu_ctr;
  xlen_t    i_src_a;
  xlen_t    i_src_b;
  xlen_t    i_imm;
  logic     i_word_cut;
  logic     i_out_ready;
  logic     o_valid;
  xlen_t    o_result;
  logic     o_zero;
  logic     o_less;

  int errors;
  int checks;
  int ops_run;

  exu i_dut (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_alu_ctr   (i_alu_ctr),
    .i_src_a     (i_src_a),
    .i_src_b     (i_src_b),
    .i_imm       (i_imm),
    .i_word_cut  (i_word_cut),
    .i_out_ready (i_out_ready),
    .o_valid     (o_valid),
    .o_result    (o_result),
    .o_zero      (o_zero),
    .o_less      (o_less)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 80 cycles per op cover a doubleword divide with room to spare
  initial begin
    repeat (NUM_OPS * 80 + MARGIN_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d ops, the run is stuck", ops_run);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic xlen_t rand_word();
    rand_word = {$urandom, $urandom};
  endfunction

  function automatic xlen_t sign_extend_word(input xlen_t v);
    sign_extend_word = {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic is_divide(input alu_ctr_t ctr);
    is_divide = (ctr == `ALU_DIV) || (ctr == `ALU_DIVU) ||
                (ctr == `ALU_REM) || (ctr == `ALU_REMU);
  endfunction

  // RISC-V rules for zero divisor and signed overflow
  function automatic xlen_t divide_model(input xlen_t a, input xlen_t b,
                                         input logic sgn, input logic rem, input logic w);
    xlen_t x;
    xlen_t y;
    xlen_t q;
    xlen_t r;
    x = w ? (sgn ? sign_extend_word(a) : {32'b0, a[31:0]}) : a;
    y = w ? (sgn ? sign_extend_word(b) : {32'b0, b[31:0]}) : b;
    if (y == '0) begin
      q = '1;
      r = x;
    end else if (sgn && x == {1'b1, 63'b0} && y == '1) begin
      q = x;
      r = '0;
    end else if (sgn) begin
      q = $signed(x) / $signed(y);
      r = $signed(x) % $signed(y);
    end else begin
      q = x / y;
      r = x % y;
    end
    divide_model = rem ? r : q;
    if (w) begin
      divide_model = sign_extend_word(divide_model);
    end
  endfunction

  function automatic xlen_t expect_result(input alu_ctr_t ctr, input xlen_t a, input xlen_t b,
                                          input xlen_t imm, input logic w);
    logic signed [127:0] sa;
    logic signed [127:0] sb;
    logic [127:0]        ua;
    logic [127:0]        ub;
    logic [127:0]        full;
    xlen_t               r;
    sa = $signed(a);
    sb = $signed(b);
    ua = {64'b0, a};
    ub = {64'b0, b};
    full = '0;
    case (ctr)
      `ALU_ADD:    r = a + b;
      `ALU_SUB:    r = a - b;
      `ALU_SLT:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      `ALU_SLTU:   r = (a < b) ? 64'd1 : 64'd0;
      `ALU_XOR:    r = a ^ b;
      `ALU_AND:    r = a & b;
      `ALU_OR:     r = a | b;
      `ALU_SLL:    r = w ? a << b[4:0] : a << b[5:0];
      `ALU_SRL:    r = w ? {32'b0, a[31:0]} >> b[4:0] : a >> b[5:0];
      `ALU_SRA:    r = w ? $signed(sign_extend_word(a)) >>> b[4:0] : $signed(a) >>> b[5:0];
      `ALU_COPY:   r = imm;
      `ALU_DIV:    r = divide_model(a, b, 1'b1, 1'b0, w);
      `ALU_DIVU:   r = divide_model(a, b, 1'b0, 1'b0, w);
      `ALU_REM:    r = divide_model(a, b, 1'b1, 1'b1, w);
      `ALU_REMU:   r = divide_model(a, b, 1'b0, 1'b1, w);
      default: begin
        if (ctr == `ALU_MULHU) begin
          full = ua * ub;
        end else if (ctr == `ALU_MULHSU) begin
          full = sa * $signed(ub);
        end else begin
          full = sa * sb;
        end
        r = (ctr == `ALU_MUL) ? full[63:0] : full[127:64];
      end
    endcase
    expect_result = w ? sign_extend_word(r) : r;
  endfunction

  function automatic logic expect_less(input alu_ctr_t ctr, input xlen_t a, input xlen_t b);
    if (ctr == `ALU_SLT) begin
      expect_less = $signed(a) < $signed(b);
    end else if (ctr == `ALU_SLTU) begin
      expect_less = a < b;
    end else begin
      expect_less = 1'b0;
    end
  endfunction

  task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic wait_until_ready(input string name);
    int waited;
    waited = 0;
    while (!o_ready && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!o_ready) begin
      errors++;
      $display("%s: DUT never raised o_ready within %0d cycles", name, READY_LIMIT);
    end
  endtask

  // one op through the DUT with i_out_ready low for stall cycles
  task automatic run_op(input string name, input alu_ctr_t ctr, input xlen_t a, input xlen_t b,
                        input xlen_t imm, input logic w, input int stall);
    xlen_t exp_res;
    logic  exp_zero;
    logic  exp_less;
    xlen_t held;
    int    waited;
    exp_res  = expect_result(ctr, a, b, imm, w);
    exp_zero = (a == b);
    exp_less = expect_less(ctr, a, b);
    wait_until_ready(name);
    i_valid     = 1'b1;
    i_alu_ctr   = ctr;
    i_src_a     = a;
    i_src_b     = b;
    i_imm       = imm;
    i_word_cut  = w;
    i_out_ready = (stall == 0);
    @(negedge clk);
    // scramble the operands once accepted since the DUT holds its own copy
    i_valid = 1'b0;
    i_src_a = rand_word();
    i_src_b = rand_word();
    i_imm   = rand_word();
    waited  = 0;
    while (!o_valid && waited < DONE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    ops_run++;
    if (!o_valid) begin
      errors++;
      $display("%s: no result within %0d cycles of acceptance", name, DONE_LIMIT);
    end else begin
      if (!is_divide(ctr) && waited != 0) begin
        errors++;
        $display("%s: ALU result came %0d cycles late", name, waited);
      end
      check_word(name, exp_res, o_result);
      check_flag({name, " zero"}, exp_zero, o_zero);
      check_flag({name, " less"}, exp_less, o_less);
      held = o_result;
      for (int i = 0; i < stall; i++) begin
        i_valid   = 1'b1;
        i_alu_ctr = alu_ctr_t'($urandom);
        i_src_a   = rand_word();
        @(negedge clk);
        check_flag({name, " valid held"}, 1'b1, o_valid);
        check_word({name, " result held"}, held, o_result);
        check_flag({name, " ready low"}, 1'b0, o_ready);
      end
      i_valid     = 1'b0;
      i_out_ready = 1'b1;
      @(negedge clk);
      check_flag({name, " taken once"}, 1'b0, o_valid);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic arith_pair(input xlen_t a, input xlen_t b, input logic w);
    run_op($sformatf("add w=%0d", w), `ALU_ADD, a, b, '0, w, 0);
    run_op($sformatf("sub w=%0d", w), `ALU_SUB, a, b, '0, w, 0);
    run_op($sformatf("xor w=%0d", w), `ALU_XOR, a, b, '0, w, 0);
    run_op($sformatf("and w=%0d", w), `ALU_AND, a, b, '0, w, 0);
    run_op($sformatf("or w=%0d", w), `ALU_OR, a, b, '0, w, 0);
    run_op($sformatf("copy w=%0d", w), `ALU_COPY, a, b, rand_word(), w, 0);
  endtask

  task automatic arith_and_logic();
    int e0;
    e0 = errors;
    for (int w = 0; w < 2; w++) begin
      arith_pair('0, '0, w[0]);
      arith_pair('1, 64'd1, w[0]);
      arith_pair({1'b1, 63'b0}, '1, w[0]);
      arith_pair(64'h0000_0000_7fff_ffff, 64'd1, w[0]);
      arith_pair(rand_word(), rand_word(), w[0]);
      arith_pair(rand_word(), rand_word(), w[0]);
    end
    report_test("arith and logic", e0);
  endtask

  task automatic shift_set(input xlen_t a, input xlen_t b, input logic w);
    run_op($sformatf("sll w=%0d", w), `ALU_SLL, a, b, '0, w, 0);
    run_op($sformatf("srl w=%0d", w), `ALU_SRL, a, b, '0, w, 0);
    run_op($sformatf("sra w=%0d", w), `ALU_SRA, a, b, '0, w, 0);
  endtask

  task automatic shift_ops();
    int e0;
    e0 = errors;
    for (int w = 0; w < 2; w++) begin
      shift_set({1'b1, 63'h5a5}, 64'd63, w[0]);
      shift_set(64'h0000_0000_8000_1234, 64'd31, w[0]);
      for (int i = 0; i < 6; i++) begin
        shift_set(rand_word(), rand_word(), w[0]);
      end
    end
    report_test("shifts", e0);
  endtask

  task automatic multiply_set(input xlen_t a, input xlen_t b);
    run_op("mul", `ALU_MUL, a, b, '0, 1'b0, 0);
    run_op("mulw", `ALU_MUL, a, b, '0, 1'b1, 0);
    run_op("mulh", `ALU_MULH, a, b, '0, 1'b0, 0);
    run_op("mulhsu", `ALU_MULHSU, a, b, '0, 1'b0, 0);
    run_op("mulhu", `ALU_MULHU, a, b, '0, 1'b0, 0);
  endtask

  task automatic multiply_ops();
    int e0;
    e0 = errors;
    multiply_set('1, '1);
    multiply_set({1'b1, 63'b0}, {1'b1, 63'b0});
    multiply_set({1'b1, 63'b0}, 64'd3);
    for (int i = 0; i < 3; i++) begin
      multiply_set(rand_word(), rand_word());
    end
    report_test("multiplies", e0);
  endtask

  task automatic divide_set(input xlen_t a, input xlen_t b);
    for (int w = 0; w < 2; w++) begin
      run_op($sformatf("div w=%0d", w), `ALU_DIV, a, b, '0, w[0], 0);
      run_op($sformatf("divu w=%0d", w), `ALU_DIVU, a, b, '0, w[0], 0);
      run_op($sformatf("rem w=%0d", w), `ALU_REM, a, b, '0, w[0], 0);
      run_op($sformatf("remu w=%0d", w), `ALU_REMU, a, b, '0, w[0], 0);
    end
  endtask

  task automatic divide_ops();
    int e0;
    e0 = errors;
    divide_set(rand_word(), rand_word());
    divide_set(rand_word(), '0);
    divide_set({1'b1, 63'b0}, '1);
    divide_set(64'hffff_ffff_8000_0000, '1);
    divide_set(-64'sd7, 64'd2);
    divide_set(64'd7, -64'sd2);
    divide_set(rand_word(), rand_word() & 64'hffff);
    report_test("divide and remainder", e0);
  endtask

  task automatic flag_cases();
    xlen_t x;
    int    e0;
    e0 = errors;
    x  = rand_word();
    run_op("zero on sub", `ALU_SUB, x, x, '0, 1'b0, 0);
    run_op("zero on add", `ALU_ADD, x, x, '0, 1'b0, 0);
    run_op("slt -1 vs 1", `ALU_SLT, '1, 64'd1, '0, 1'b0, 0);
    run_op("sltu -1 vs 1", `ALU_SLTU, '1, 64'd1, '0, 1'b0, 0);
    run_op("slt 1 vs -1", `ALU_SLT, 64'd1, '1, '0, 1'b0, 0);
    run_op("sltu 1 vs -1", `ALU_SLTU, 64'd1, '1, '0, 1'b0, 0);
    report_test("flags", e0);
  endtask

  task automatic back_pressure();
    int e0;
    e0 = errors;
    run_op("bp add", `ALU_ADD, rand_word(), rand_word(), '0, 1'b0, 1 + $urandom % 8);
    run_op("bp xor", `ALU_XOR, rand_word(), rand_word(), '0, 1'b1, 1 + $urandom % 8);
    run_op("bp sll", `ALU_SLL, rand_word(), rand_word(), '0, 1'b0, 1 + $urandom % 8);
    run_op("bp mulhu", `ALU_MULHU, rand_word(), rand_word(), '0, 1'b0, 1 + $urandom % 8);
    run_op("bp copy", `ALU_COPY, '0, '0, rand_word(), 1'b0, 1 + $urandom % 8);
    run_op("bp sra", `ALU_SRA, rand_word(), rand_word(), '0, 1'b1, 1 + $urandom % 8);
    run_op("bp div", `ALU_DIV, rand_word(), rand_word(), '0, 1'b0, 1 + $urandom % 8);
    run_op("bp remu", `ALU_REMU, rand_word(), rand_word(), '0, 1'b1, 1 + $urandom % 8);
    run_op("bp divu", `ALU_DIVU, rand_word(), '0, '0, 1'b0, 1 + $urandom % 8);
    run_op("bp rem", `ALU_REM, rand_word(), rand_word(), '0, 1'b1, 1 + $urandom % 8);
    report_test("back-pressure", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    errors      = 0;
    checks      = 0;
    ops_run     = 0;
    rst_n       = 1'b0;
    i_valid     = 1'b0;
    i_alu_ctr   = '0;
    i_src_a     = '0;
    i_src_b     = '0;
    i_imm       = '0;
    i_word_cut  = 1'b0;
    i_out_ready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_flag("reset valid", 1'b0, o_valid);
    check_flag("reset ready", 1'b1, o_ready);
    arith_and_logic();
    shift_ops();
    multiply_ops();
    divide_ops();
    flag_cases();
    back_pressure();
    $display("%0d ops, %0d checks, %0d errors", ops_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/exu_pkg.sv
rtl/mux_key.sv
alu/alu.sv
alu/alu_divider.sv
rtl/exu.sv
dv/exu_tb.sv
